/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
TOP       ?= tb_sram
FLIST     ?= build.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

/* build.f */
common/sram_pkg.sv
verilog/lfsr8.sv
sram/sram_array.sv
sram/sram_read_port.sv
sram/sram_write_port.sv
verilog/sram_axi_top.sv
tb/sram_checker.sv
tb/tb_sram.sv

/* common/sram_pkg.sv */
package sram_pkg;

  // Bus and storage widths.
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  index_t;

  localparam int MEM_DEPTH = 256;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // The shortest wait of a channel, in cycles.
  localparam int LAT_MIN = 2;
  // Adding this many random bits to LAT_MIN gives waits of 2 to 9 cycles.
  localparam int LAT_BITS = 3;

  localparam logic [7:0] LFSR_SEED = 8'b1010_1010;

  // Both channel engines step through these states.
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } chan_state_t;

endpackage

/* sram/sram_array.sv */
`timescale 1ns/10ps

module sram_array
  import sram_pkg::*;
(
  input  logic   clk,

  input  index_t rd_index,
  output word_t  rd_word,

  input  logic   wr_en,
  input  index_t wr_index,
  input  word_t  wr_word,
  input  strb_t  wr_strb
);

  localparam int LANES = $bits(strb_t);

  word_t mem [MEM_DEPTH];

  // The read is asynchronous and the engines register the word themselves.
  assign rd_word = mem[rd_index];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int lane = 0; lane < LANES; lane++) begin
        if (wr_strb[lane]) begin
          mem[wr_index][8*lane +: 8] <= wr_word[8*lane +: 8];
        end
      end
    end
  end

endmodule

/* sram/sram_read_port.sv */
`timescale 1ns/10ps

module sram_read_port
  import sram_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic [LAT_BITS-1:0] lfsr_bits,

  input  addr_t               araddr,
  input  logic                arvalid,
  output logic                arready,

  output word_t               rdata,
  output resp_t               rresp,
  output logic                rvalid,
  input  logic                rready,

  output index_t              rd_index,
  input  word_t               rd_word
);

  typedef logic [LAT_BITS:0] cnt_t;

  chan_state_t state;
  cnt_t        count;
  addr_t       raddr_q;
  logic        ar_hs;
  logic        r_hs;
  logic        expire;
  logic        in_range;

  assign arready = (state == IDLE);
  assign rvalid  = (state == RESP);

  assign ar_hs  = arvalid & arready;
  assign r_hs   = rvalid & rready;
  assign expire = (state == WAIT) && (count == cnt_t'(1));

  // Only 1 KiB is decoded. Bits 1..0 select a byte and are ignored.
  assign in_range = ~|raddr_q[31:10];
  assign rd_index = raddr_q[9:2];

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (ar_hs) begin
            state <= WAIT;
            count <= cnt_t'(LAT_MIN) + cnt_t'(lfsr_bits);
          end
        end
        WAIT: begin
          if (expire) begin
            state <= RESP;
          end else begin
            count <= count - cnt_t'(1);
          end
        end
        RESP: begin
          if (r_hs) state <= IDLE;  // Next address is accepted from here on.
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) raddr_q <= araddr;
    if (expire) begin
      if (in_range) begin
        rdata <= rd_word;
        rresp <= RESP_OKAY;
      end else begin
        rdata <= '0;  // Out of range reads return zero.
        rresp <= RESP_SLVERR;
      end
    end
  end

endmodule

/* sram/sram_write_port.sv */
`timescale 1ns/10ps

module sram_write_port
  import sram_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic [LAT_BITS-1:0] lfsr_bits,

  input  addr_t               awaddr,
  input  logic                awvalid,
  output logic                awready,

  input  word_t               wdata,
  input  strb_t               wstrb,
  input  logic                wvalid,
  output logic                wready,

  output resp_t               bresp,
  output logic                bvalid,
  input  logic                bready,

  output logic                wr_en,
  output index_t              wr_index,
  output word_t               wr_word,
  output strb_t               wr_strb
);

  typedef logic [LAT_BITS:0] cnt_t;

  chan_state_t state;
  cnt_t        count;
  logic        aw_held;
  logic        w_held;
  addr_t       waddr_q;
  word_t       wdata_q;
  strb_t       wstrb_q;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        both_held;
  logic        expire;
  logic        in_range;

  // Each ready drops on its own transfer and both come back with the response.
  assign awready = ~aw_held;
  assign wready  = ~w_held;
  assign bvalid  = (state == RESP);

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;

  // True on the edge where the second half of the request arrives.
  assign both_held = (aw_hs | aw_held) & (w_hs | w_held);

  assign expire   = (state == WAIT) && (count == cnt_t'(1));
  assign in_range = ~|waddr_q[31:10];

  // The array commits on the same edge that raises bvalid.
  assign wr_en    = expire & in_range;
  assign wr_index = waddr_q[9:2];
  assign wr_word  = wdata_q;
  assign wr_strb  = wstrb_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      state   <= IDLE;
      count   <= '0;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      if (aw_hs) aw_held <= 1'b1;
      if (w_hs) w_held <= 1'b1;
      case (state)
        IDLE: begin
          if (both_held) begin
            state <= WAIT;
            count <= cnt_t'(LAT_MIN) + cnt_t'(lfsr_bits);
          end
        end
        WAIT: begin
          if (expire) begin
            state <= RESP;
          end else begin
            count <= count - cnt_t'(1);
          end
        end
        RESP: begin
          if (b_hs) begin
            state   <= IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) waddr_q <= awaddr;
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (expire) bresp <= in_range ? RESP_OKAY : RESP_SLVERR;
  end

endmodule

/* tb/sram_checker.sv */
`timescale 1ns/10ps

module sram_checker
  import sram_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  addr_t araddr,
  input  logic  arvalid,
  input  logic  arready,
  input  word_t rdata,
  input  resp_t rresp,
  input  logic  rvalid,
  input  logic  rready,
  input  addr_t awaddr,
  input  logic  awvalid,
  input  logic  awready,
  input  word_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  input  logic  wready,
  input  resp_t bresp,
  input  logic  bvalid,
  input  logic  bready,
  input  resp_t exp_bresp,
  input  resp_t exp_rresp,
  input  logic  test_done,
  input  int    test_id,
  output int    tests_passed,
  output int    tests_failed,
  output int    checks,
  output int    errors
);

  word_t shadow [MEM_DEPTH];
  addr_t ar_addr_q;
  addr_t aw_addr_q;
  word_t w_data_q;
  strb_t w_strb_q;
  logic  in_reset = 1'b0;
  logic  r_hold = 1'b0;
  logic  b_hold = 1'b0;
  word_t r_held_data;
  resp_t r_held_resp;
  resp_t b_held_resp;
  int    n_passed = 0;
  int    n_failed = 0;
  int    n_checks = 0;
  int    n_errors = 0;
  int    errors_mark = 0;

  assign tests_passed = n_passed;
  assign tests_failed = n_failed;
  assign checks       = n_checks;
  assign errors       = n_errors;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    if (n_errors == errors_mark) begin
      n_passed++;
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", name, n_errors - errors_mark);
    end
    errors_mark = n_errors;
  endtask

  // Everything is sampled at the falling edge, where the values that the next
  // rising edge will act on are settled.
  always @(negedge clk) begin
    if (rstn) begin
      in_reset = 1'b1;
    end else begin
      if (in_reset) begin
        check_value("arready", 32'd1, 32'(arready));
        check_value("awready", 32'd1, 32'(awready));
        check_value("wready", 32'd1, 32'(wready));
        check_value("rvalid", 32'd0, 32'(rvalid));
        check_value("bvalid", 32'd0, 32'(bvalid));
        report_test("reset values");
        in_reset = 1'b0;
      end
      if (arvalid && arready) ar_addr_q = araddr;
      if (awvalid && awready) aw_addr_q = awaddr;
      if (wvalid && wready) begin
        w_data_q = wdata;
        w_strb_q = wstrb;
      end

      // A response that was not taken must still be there, unchanged.
      if (r_hold) begin
        check_value("rvalid", 32'd1, 32'(rvalid));
        check_value("rdata", r_held_data, rdata);
        check_value("rresp", 32'(r_held_resp), 32'(rresp));
      end
      if (b_hold) begin
        check_value("bvalid", 32'd1, 32'(bvalid));
        check_value("bresp", 32'(b_held_resp), 32'(bresp));
      end
      r_hold      = rvalid && !rready;
      r_held_data = rdata;
      r_held_resp = rresp;
      b_hold      = bvalid && !bready;
      b_held_resp = bresp;

      if (rvalid && rready) begin
        check_value("rresp", 32'(exp_rresp), 32'(rresp));
        check_value("rdata", (ar_addr_q[31:10] == '0) ? shadow[ar_addr_q[9:2]] : word_t'(0),
                    rdata);
      end
      if (bvalid && bready) begin
        check_value("bresp", 32'(exp_bresp), 32'(bresp));
        if (aw_addr_q[31:10] == '0) begin
          for (int lane = 0; lane < 4; lane++) begin
            if (w_strb_q[lane]) shadow[aw_addr_q[9:2]][8*lane +: 8] = w_data_q[8*lane +: 8];
          end
        end
      end

      if (test_done) report_test($sformatf("row %0d", test_id));
    end
  end

endmodule

/* tb/tb_sram.sv */
`timescale 1ns/10ps

module tb_sram
  import sram_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int MAX_STALL  = 4;
  // Two address edges, the longest wait, the stall and the closing edges of a row.
  localparam int ROW_CYCLES = 9 + MAX_STALL + 4;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_WR_RD} op_t;
  typedef enum logic [1:0] {AW_FIRST, W_FIRST, SAME_EDGE} order_t;

  typedef struct packed {
    op_t    op;
    order_t order;
    addr_t  waddr;
    addr_t  raddr;
    word_t  data;
    strb_t  strb;
    resp_t  exp_bresp;
    resp_t  exp_rresp;
  } row_t;

  logic  clk;
  logic  rstn;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  word_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  word_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  resp_t exp_bresp;
  resp_t exp_rresp;
  logic  test_done;
  int    test_id;
  int    tests_passed;
  int    tests_failed;
  int    checks;
  int    errors;

  row_t        rows[$];
  logic [31:0] lcg_state = 32'h759aad6f;

  sram_axi_top i_dut (.*);

  sram_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic void add_row(op_t op, order_t order, addr_t waddr, addr_t raddr,
                                  word_t data, strb_t strb, resp_t exp_b, resp_t exp_r);
    rows.push_back('{op, order, waddr, raddr, data, strb, exp_b, exp_r});
  endfunction

  function automatic void build_table();
    addr_t a;
    word_t d;
    for (int i = 0; i < 6; i++) begin
      d = next_random();
      a = {22'd0, d[23:16], 2'b00};
      d = next_random();
      add_row(OP_WR, SAME_EDGE, a, '0, d, 4'hf, RESP_OKAY, RESP_OKAY);
      add_row(OP_RD, SAME_EDGE, '0, a, '0, '0, RESP_OKAY, RESP_OKAY);
    end
    // Byte merges into word 8, the last one through an unaligned address.
    add_row(OP_WR, SAME_EDGE, 32'h20, '0, 32'h1122_3344, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, SAME_EDGE, 32'h20, '0, 32'haabb_ccdd, 4'h5, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h20, '0, '0, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, AW_FIRST, 32'h20, '0, 32'h5566_7788, 4'h8, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h20, '0, '0, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, W_FIRST, 32'h23, '0, 32'h0000_ee00, 4'h2, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h22, '0, '0, RESP_OKAY, RESP_OKAY);
    d = next_random();
    add_row(OP_WR, AW_FIRST, 32'h40, '0, d, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, W_FIRST, 32'h44, '0, d, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, SAME_EDGE, 32'h48, '0, d, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h40, '0, '0, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h44, '0, '0, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h48, '0, '0, RESP_OKAY, RESP_OKAY);
    // High address bits alias onto word 4 and must leave it alone.
    d = next_random();
    add_row(OP_WR, SAME_EDGE, 32'h10, '0, d, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, SAME_EDGE, 32'h0001_0010, '0, ~d, 4'hf, RESP_SLVERR, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h0001_0010, '0, '0, RESP_OKAY, RESP_SLVERR);
    add_row(OP_RD, SAME_EDGE, '0, 32'h10, '0, '0, RESP_OKAY, RESP_OKAY);
    add_row(OP_WR, W_FIRST, 32'h8000_0010, '0, ~d, 4'h3, RESP_SLVERR, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h10, '0, '0, RESP_OKAY, RESP_OKAY);
    d = next_random();
    add_row(OP_WR_RD, SAME_EDGE, 32'h80, 32'h20, d, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h80, '0, '0, RESP_OKAY, RESP_OKAY);
    d = next_random();
    add_row(OP_WR_RD, W_FIRST, 32'h84, 32'h10, d, 4'hf, RESP_OKAY, RESP_OKAY);
    add_row(OP_RD, SAME_EDGE, '0, 32'h84, '0, '0, RESP_OKAY, RESP_OKAY);
  endfunction

  // Inputs change 2 ns after the rising edge.
  task automatic advance_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic send_aw(input addr_t addr);
    awaddr  = addr;
    awvalid = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    advance_cycle();
    awvalid = 1'b0;
  endtask

  task automatic send_w(input word_t data, input strb_t strb);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    @(negedge clk);
    while (!wready) @(negedge clk);
    advance_cycle();
    wvalid = 1'b0;
  endtask

  task automatic send_ar(input addr_t addr);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    advance_cycle();
    arvalid = 1'b0;
  endtask

  task automatic collect_b(input int stall);
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    repeat (stall) advance_cycle();  // The response waits with bready low.
    bready = 1'b1;
    @(negedge clk);
    while (!(bvalid && bready)) @(negedge clk);
    advance_cycle();
    bready = 1'b0;
  endtask

  task automatic collect_r(input int stall);
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    repeat (stall) advance_cycle();
    rready = 1'b1;
    @(negedge clk);
    while (!(rvalid && rready)) @(negedge clk);
    advance_cycle();
    rready = 1'b0;
  endtask

  task automatic run_write(input row_t row, input int stall);
    case (row.order)
      AW_FIRST: begin
        send_aw(row.waddr);
        send_w(row.data, row.strb);
      end
      W_FIRST: begin
        send_w(row.data, row.strb);
        send_aw(row.waddr);
      end
      default: fork
        send_aw(row.waddr);
        send_w(row.data, row.strb);
      join
    endcase
    collect_b(stall);
  endtask

  task automatic run_read(input addr_t addr, input int stall);
    send_ar(addr);
    collect_r(stall);
  endtask

  initial begin
    row_t row;
    int   wstall;
    int   rstall;
    rstn      = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    exp_bresp = RESP_OKAY;
    exp_rresp = RESP_OKAY;
    test_done = 1'b0;
    test_id   = 0;
    build_table();
    repeat (4) @(posedge clk);
    #2;
    rstn = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      row       = rows[i];
      wstall    = 1 + int'(next_random() >> 30);  // The upper two bits give 1 to MAX_STALL.
      rstall    = 1 + int'(next_random() >> 30);
      test_id   = i;
      exp_bresp = row.exp_bresp;
      exp_rresp = row.exp_rresp;
      case (row.op)
        OP_WR: run_write(row, wstall);
        OP_RD: run_read(row.raddr, rstall);
        default: fork
          run_write(row, wstall);
          run_read(row.raddr, rstall);
        join
      endcase
      test_done = 1'b1;
      advance_cycle();
      test_done = 1'b0;
    end
    advance_cycle();
    $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = (rows.size() * ROW_CYCLES + 4 + 50) * CLK_PERIOD;
    #(limit);
    $display("Watchdog: no result after %0d ns, a transfer never completed.", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog/lfsr8.sv */
`timescale 1ns/10ps

module lfsr8
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  output logic [7:0] value
);

  logic [7:0] state;
  logic       feedback;

  // Taps 8, 6, 5 and 4 give a maximal length sequence of 255 states.
  assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= LFSR_SEED;
    end else begin
      state <= {state[6:0], feedback};
    end
  end

  assign value = state;

endmodule

/* verilog/sram_axi_top.sv */
`timescale 1ns/10ps

module sram_axi_top
  import sram_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,

  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,

  output word_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,

  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,

  input  word_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,

  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready
);

  logic [7:0] lfsr_value;
  index_t     rd_index;
  word_t      rd_word;
  logic       wr_en;
  index_t     wr_index;
  word_t      wr_word;
  strb_t      wr_strb;

  lfsr8 i_lfsr (
    .clk   (clk),
    .rstn  (rstn),
    .value (lfsr_value)
  );

  sram_array i_array (
    .clk      (clk),
    .rd_index (rd_index),
    .rd_word  (rd_word),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_word  (wr_word),
    .wr_strb  (wr_strb)
  );

  // Disjoint LFSR bits keep the two channel latencies apart.
  sram_read_port i_read (
    .clk       (clk),
    .rstn      (rstn),
    .lfsr_bits (lfsr_value[2:0]),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rd_index  (rd_index),
    .rd_word   (rd_word)
  );

  sram_write_port i_write (
    .clk       (clk),
    .rstn      (rstn),
    .lfsr_bits (lfsr_value[5:3]),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .wr_en     (wr_en),
    .wr_index  (wr_index),
    .wr_word   (wr_word),
    .wr_strb   (wr_strb)
  );

endmodule
